//--- Makefile
# Verilator simulation of the AXI read ID serializer

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= axi_id_serialize_rd.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- axi_id_serialize_rd.f
source/axi_ser_cfg_pkg.sv
source/axi_ser_chan_pkg.sv
source/id_fifo.sv
source/ar_lane_demux.sv
source/lane_serializer.sv
source/lane_ar_mux.sv
source/axi_id_serialize_rd.sv
verification/tb_checker.sv
verification/tb_top.sv

//--- source/ar_lane_demux.sv
module ar_lane_demux (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic                                       s_ar_valid_i,
  output logic                                       s_ar_ready_o,
  input  axi_ser_chan_pkg::slv_id_u                  s_ar_id_i,
  input  axi_ser_chan_pkg::addr_t                    s_ar_addr_i,
  input  axi_ser_chan_pkg::len_t                     s_ar_len_i,
  output logic [axi_ser_cfg_pkg::NUM_LANES-1:0]      lane_ar_valid_o,
  input  logic [axi_ser_cfg_pkg::NUM_LANES-1:0]      lane_ar_ready_i,
  output axi_ser_chan_pkg::slv_id_t                  lane_ar_id_o,
  output axi_ser_chan_pkg::addr_t                    lane_ar_addr_o,
  output axi_ser_chan_pkg::len_t                     lane_ar_len_o
);

  logic                      full_q;
  axi_ser_chan_pkg::slv_id_u id_q;
  axi_ser_chan_pkg::addr_t   addr_q;
  axi_ser_chan_pkg::len_t    len_q;
  logic                      lane_take;
  logic                      slv_take;

  // Held entry leaves when its selected lane accepts it
  assign lane_take = full_q && lane_ar_ready_i[id_q.fields.sel];

  // Room when empty, or when the entry drains in this very cycle
  assign s_ar_ready_o = !full_q || lane_take;
  assign slv_take     = s_ar_valid_i && s_ar_ready_o;

  // Only the selected lane sees valid, payload is common
  always_comb begin
    lane_ar_valid_o                     = '0;
    lane_ar_valid_o[id_q.fields.sel]    = full_q;
  end

  assign lane_ar_id_o   = id_q.raw;
  assign lane_ar_addr_o = addr_q;
  assign lane_ar_len_o  = len_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (slv_take) begin
      full_q <= 1'b1;
    end else if (lane_take) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (slv_take) begin
      id_q   <= s_ar_id_i;
      addr_q <= s_ar_addr_i;
      len_q  <= s_ar_len_i;
    end
  end

endmodule

//--- source/axi_id_serialize_rd.sv
module axi_id_serialize_rd (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // Slave AR
  input  logic                      s_ar_valid_i,
  output logic                      s_ar_ready_o,
  input  axi_ser_chan_pkg::slv_id_t s_ar_id_i,
  input  axi_ser_chan_pkg::addr_t   s_ar_addr_i,
  input  axi_ser_chan_pkg::len_t    s_ar_len_i,
  // Slave R
  output logic                      s_r_valid_o,
  input  logic                      s_r_ready_i,
  output axi_ser_chan_pkg::slv_id_t s_r_id_o,
  output axi_ser_chan_pkg::data_t   s_r_data_o,
  output logic                      s_r_last_o,
  // Master AR
  output logic                      m_ar_valid_o,
  input  logic                      m_ar_ready_i,
  output axi_ser_chan_pkg::mst_id_t m_ar_id_o,
  output axi_ser_chan_pkg::addr_t   m_ar_addr_o,
  output axi_ser_chan_pkg::len_t    m_ar_len_o,
  // Master R
  input  logic                      m_r_valid_i,
  output logic                      m_r_ready_o,
  input  axi_ser_chan_pkg::mst_id_t m_r_id_i,
  input  axi_ser_chan_pkg::data_t   m_r_data_i,
  input  logic                      m_r_last_i
);

  localparam int unsigned NL = axi_ser_cfg_pkg::NUM_LANES;

  // Demux to lanes
  logic [NL-1:0]             dmx_ar_valid;
  logic [NL-1:0]             dmx_ar_ready;
  axi_ser_chan_pkg::slv_id_t dmx_ar_id;
  axi_ser_chan_pkg::addr_t   dmx_ar_addr;
  axi_ser_chan_pkg::len_t    dmx_ar_len;

  // Lanes to mux
  logic [NL-1:0]                    ln_ar_valid;
  logic [NL-1:0]                    ln_ar_ready;
  axi_ser_chan_pkg::addr_t [NL-1:0] ln_ar_addr;
  axi_ser_chan_pkg::len_t [NL-1:0]  ln_ar_len;
  logic [NL-1:0]                    ln_r_valid;
  logic [NL-1:0]                    ln_r_ready;
  axi_ser_chan_pkg::data_t          mux_r_data;
  logic                             mux_r_last;
  axi_ser_chan_pkg::lane_sel_t      grant_r;

  // Per-lane restored R
  logic [NL-1:0]                      ln_s_r_valid;
  axi_ser_chan_pkg::slv_id_t [NL-1:0] ln_s_r_id;

  ar_lane_demux i_ar_lane_demux (
    .clk_i           ( clk_i        ),
    .rst_i           ( rst_i        ),
    .s_ar_valid_i    ( s_ar_valid_i ),
    .s_ar_ready_o    ( s_ar_ready_o ),
    .s_ar_id_i       ( s_ar_id_i    ),
    .s_ar_addr_i     ( s_ar_addr_i  ),
    .s_ar_len_i      ( s_ar_len_i   ),
    .lane_ar_valid_o ( dmx_ar_valid ),
    .lane_ar_ready_i ( dmx_ar_ready ),
    .lane_ar_id_o    ( dmx_ar_id    ),
    .lane_ar_addr_o  ( dmx_ar_addr  ),
    .lane_ar_len_o   ( dmx_ar_len   )
  );

  for (genvar i = 0; i < NL; i++) begin : gen_lanes
    lane_serializer i_lane_serializer (
      .clk_i        ( clk_i           ),
      .rst_i        ( rst_i           ),
      .ar_valid_i   ( dmx_ar_valid[i] ),
      .ar_ready_o   ( dmx_ar_ready[i] ),
      .ar_id_i      ( dmx_ar_id       ),
      .ar_addr_i    ( dmx_ar_addr     ),
      .ar_len_i     ( dmx_ar_len      ),
      .m_ar_valid_o ( ln_ar_valid[i]  ),
      .m_ar_ready_i ( ln_ar_ready[i]  ),
      .m_ar_addr_o  ( ln_ar_addr[i]   ),
      .m_ar_len_o   ( ln_ar_len[i]    ),
      .r_valid_i    ( ln_r_valid[i]   ),
      .r_ready_o    ( ln_r_ready[i]   ),
      .r_data_i     ( mux_r_data      ),
      .r_last_i     ( mux_r_last      ),
      .s_r_valid_o  ( ln_s_r_valid[i] ),
      .s_r_ready_i  ( s_r_ready_i     ),
      .s_r_id_o     ( ln_s_r_id[i]    ),
      .s_r_data_o   (                 ),
      .s_r_last_o   (                 )
    );
  end

  lane_ar_mux i_lane_ar_mux (
    .clk_i           ( clk_i        ),
    .rst_i           ( rst_i        ),
    .lane_ar_valid_i ( ln_ar_valid  ),
    .lane_ar_ready_o ( ln_ar_ready  ),
    .lane_ar_addr_i  ( ln_ar_addr   ),
    .lane_ar_len_i   ( ln_ar_len    ),
    .m_ar_valid_o    ( m_ar_valid_o ),
    .m_ar_ready_i    ( m_ar_ready_i ),
    .m_ar_id_o       ( m_ar_id_o    ),
    .m_ar_addr_o     ( m_ar_addr_o  ),
    .m_ar_len_o      ( m_ar_len_o   ),
    .m_r_valid_i     ( m_r_valid_i  ),
    .m_r_ready_o     ( m_r_ready_o  ),
    .m_r_id_i        ( m_r_id_i     ),
    .m_r_data_i      ( m_r_data_i   ),
    .m_r_last_i      ( m_r_last_i   ),
    .lane_r_valid_o  ( ln_r_valid   ),
    .lane_r_ready_i  ( ln_r_ready   ),
    .lane_r_data_o   ( mux_r_data   ),
    .lane_r_last_o   ( mux_r_last   ),
    .grant_r_o       ( grant_r      )
  );

  // Valid and restored ID come from the lane that carries the beat
  assign s_r_valid_o = ln_s_r_valid[grant_r];
  assign s_r_id_o    = ln_s_r_id[grant_r];

  // Data and last are common to all lanes
  assign s_r_data_o  = mux_r_data;
  assign s_r_last_o  = mux_r_last;

endmodule

//--- source/axi_ser_cfg_pkg.sv
package axi_ser_cfg_pkg;

  // Slave-side ID width, as seen by the upstream master
  localparam int unsigned SLV_ID_WIDTH = 4;

  // Master-side ID width, one ID per lane
  localparam int unsigned MST_ID_WIDTH = 2;

  localparam int unsigned NUM_LANES = 2 ** MST_ID_WIDTH;

  // Low slave ID bits that pick the lane (ID modulo NUM_LANES)
  localparam int unsigned SEL_WIDTH = 2;

  // Depth of the per-lane ID FIFO
  localparam int unsigned MAX_TXNS_PER_LANE = 4;

  localparam int unsigned ADDR_WIDTH = 16;
  localparam int unsigned DATA_WIDTH = 32;

  // AXI burst length field, beats minus one
  localparam int unsigned LEN_WIDTH = 8;

endpackage

//--- source/axi_ser_chan_pkg.sv
package axi_ser_chan_pkg;

  typedef logic [axi_ser_cfg_pkg::SLV_ID_WIDTH-1:0] slv_id_t;
  typedef logic [axi_ser_cfg_pkg::MST_ID_WIDTH-1:0] mst_id_t;
  typedef logic [axi_ser_cfg_pkg::ADDR_WIDTH-1:0]   addr_t;
  typedef logic [axi_ser_cfg_pkg::DATA_WIDTH-1:0]   data_t;
  typedef logic [axi_ser_cfg_pkg::LEN_WIDTH-1:0]    len_t;

  // Lane index, also the master-side ID of that lane
  typedef logic [axi_ser_cfg_pkg::SEL_WIDTH-1:0] lane_sel_t;

  // Slave ID split into the bits that are kept and the lane select.
  // The select sits in the low bits so it equals the ID modulo NUM_LANES
  typedef struct packed {
    logic [axi_ser_cfg_pkg::SLV_ID_WIDTH-axi_ser_cfg_pkg::SEL_WIDTH-1:0] upper;
    lane_sel_t                                                          sel;
  } slv_id_fields_t;

  // Lanes keep the raw word, the demux reads the select field
  typedef union packed {
    slv_id_t        raw;
    slv_id_fields_t fields;
  } slv_id_u;

endpackage

//--- source/id_fifo.sv
module id_fifo #(
  parameter int unsigned WIDTH = 4,
  parameter int unsigned DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int unsigned PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]     mem_q [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr_q;
  logic [PTR_WIDTH-1:0] rd_ptr_q;
  logic [CNT_WIDTH-1:0] count_q;
  logic                 push_en;
  logic                 pop_en;

  // Pointer wrap for depths that are not a power of two
  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_WIDTH'(DEPTH));
  assign empty_o = (count_q == '0);
  assign push_en = push_i && !full_o;
  assign pop_en  = pop_i && !empty_o;

  // Head of the queue, oldest pushed ID
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- source/lane_ar_mux.sv
module lane_ar_mux (
  input  logic                                                      clk_i,
  input  logic                                                      rst_i,
  // AR from the lanes
  input  logic [axi_ser_cfg_pkg::NUM_LANES-1:0]                     lane_ar_valid_i,
  output logic [axi_ser_cfg_pkg::NUM_LANES-1:0]                     lane_ar_ready_o,
  input  axi_ser_chan_pkg::addr_t [axi_ser_cfg_pkg::NUM_LANES-1:0]  lane_ar_addr_i,
  input  axi_ser_chan_pkg::len_t [axi_ser_cfg_pkg::NUM_LANES-1:0]   lane_ar_len_i,
  // Master AR
  output logic                                                      m_ar_valid_o,
  input  logic                                                      m_ar_ready_i,
  output axi_ser_chan_pkg::mst_id_t                                 m_ar_id_o,
  output axi_ser_chan_pkg::addr_t                                   m_ar_addr_o,
  output axi_ser_chan_pkg::len_t                                    m_ar_len_o,
  // Master R
  input  logic                                                      m_r_valid_i,
  output logic                                                      m_r_ready_o,
  input  axi_ser_chan_pkg::mst_id_t                                 m_r_id_i,
  input  axi_ser_chan_pkg::data_t                                   m_r_data_i,
  input  logic                                                      m_r_last_i,
  // R towards the lanes
  output logic [axi_ser_cfg_pkg::NUM_LANES-1:0]                     lane_r_valid_o,
  input  logic [axi_ser_cfg_pkg::NUM_LANES-1:0]                     lane_r_ready_i,
  output axi_ser_chan_pkg::data_t                                   lane_r_data_o,
  output logic                                                      lane_r_last_o,
  output axi_ser_chan_pkg::lane_sel_t                               grant_r_o
);

  axi_ser_chan_pkg::lane_sel_t rr_ptr_q;
  axi_ser_chan_pkg::lane_sel_t lock_sel_q;
  logic                        lock_q;
  axi_ser_chan_pkg::lane_sel_t arb_sel;
  axi_ser_chan_pkg::lane_sel_t cand;
  axi_ser_chan_pkg::lane_sel_t ar_sel;
  axi_ser_chan_pkg::lane_sel_t r_sel;
  logic                        found;

  // First valid lane at or after the round-robin pointer
  always_comb begin
    found   = 1'b0;
    arb_sel = rr_ptr_q;
    cand    = rr_ptr_q;
    for (int unsigned k = 0; k < axi_ser_cfg_pkg::NUM_LANES; k++) begin
      cand = axi_ser_chan_pkg::lane_sel_t'((32'(rr_ptr_q) + k) % axi_ser_cfg_pkg::NUM_LANES);
      if (!found && lane_ar_valid_i[cand]) begin
        found   = 1'b1;
        arb_sel = cand;
      end
    end
  end

  // A request already shown to the master keeps its grant
  assign ar_sel = lock_q ? lock_sel_q : arb_sel;

  assign m_ar_valid_o = lane_ar_valid_i[ar_sel];
  assign m_ar_id_o    = axi_ser_chan_pkg::mst_id_t'(ar_sel);
  assign m_ar_addr_o  = lane_ar_addr_i[ar_sel];
  assign m_ar_len_o   = lane_ar_len_i[ar_sel];

  always_comb begin
    lane_ar_ready_o         = '0;
    lane_ar_ready_o[ar_sel] = m_ar_ready_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_sel_q <= '0;
    end else if (m_ar_valid_o && m_ar_ready_i) begin
      lock_q   <= 1'b0;
      rr_ptr_q <= axi_ser_chan_pkg::lane_sel_t'((32'(ar_sel) + 1) % axi_ser_cfg_pkg::NUM_LANES);
    end else if (m_ar_valid_o) begin
      lock_q     <= 1'b1;
      lock_sel_q <= ar_sel;
    end
  end

  // R goes back by master ID, which is the lane index
  assign r_sel = axi_ser_chan_pkg::lane_sel_t'(m_r_id_i);

  always_comb begin
    lane_r_valid_o        = '0;
    lane_r_valid_o[r_sel] = m_r_valid_i;
  end

  assign lane_r_data_o = m_r_data_i;
  assign lane_r_last_o = m_r_last_i;
  assign m_r_ready_o   = lane_r_ready_i[r_sel];
  assign grant_r_o     = r_sel;

endmodule

//--- source/lane_serializer.sv
module lane_serializer (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // AR from the demux
  input  logic                      ar_valid_i,
  output logic                      ar_ready_o,
  input  axi_ser_chan_pkg::slv_id_t ar_id_i,
  input  axi_ser_chan_pkg::addr_t   ar_addr_i,
  input  axi_ser_chan_pkg::len_t    ar_len_i,
  // AR towards the mux, the ID is added there
  output logic                      m_ar_valid_o,
  input  logic                      m_ar_ready_i,
  output axi_ser_chan_pkg::addr_t   m_ar_addr_o,
  output axi_ser_chan_pkg::len_t    m_ar_len_o,
  // R routed to this lane
  input  logic                      r_valid_i,
  output logic                      r_ready_o,
  input  axi_ser_chan_pkg::data_t   r_data_i,
  input  logic                      r_last_i,
  // R with the original ID restored
  output logic                      s_r_valid_o,
  input  logic                      s_r_ready_i,
  output axi_ser_chan_pkg::slv_id_t s_r_id_o,
  output axi_ser_chan_pkg::data_t   s_r_data_o,
  output logic                      s_r_last_o
);

  logic                      id_full;
  logic                      id_empty;
  logic                      id_push;
  logic                      id_pop;
  axi_ser_chan_pkg::slv_id_t id_head;

  // Stall new requests once every slot holds an outstanding ID
  assign m_ar_valid_o = ar_valid_i && !id_full;
  assign ar_ready_o   = m_ar_ready_i && !id_full;
  assign m_ar_addr_o  = ar_addr_i;
  assign m_ar_len_o   = ar_len_i;

  assign id_push = ar_valid_i && ar_ready_o;

  // A beat with nothing outstanding is not forwarded
  assign s_r_valid_o = r_valid_i && !id_empty;
  assign r_ready_o   = s_r_ready_i && !id_empty;
  assign s_r_id_o    = id_head;
  assign s_r_data_o  = r_data_i;
  assign s_r_last_o  = r_last_i;

  // Burst done, oldest ID retires
  assign id_pop = r_valid_i && r_ready_o && r_last_i;

  id_fifo #(
    .WIDTH ( axi_ser_cfg_pkg::SLV_ID_WIDTH      ),
    .DEPTH ( axi_ser_cfg_pkg::MAX_TXNS_PER_LANE )
  ) i_id_fifo (
    .clk_i   ( clk_i    ),
    .rst_i   ( rst_i    ),
    .push_i  ( id_push  ),
    .data_i  ( ar_id_i  ),
    .pop_i   ( id_pop   ),
    .data_o  ( id_head  ),
    .full_o  ( id_full  ),
    .empty_o ( id_empty )
  );

endmodule

//--- verification/tb_checker.sv
module tb_checker #(
  parameter int unsigned NAME_W = 80
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [NAME_W-1:0]         test_name_i,
  input  logic                      s_ar_valid_i,
  input  logic                      s_ar_ready_o,
  input  axi_ser_chan_pkg::slv_id_t s_ar_id_i,
  input  axi_ser_chan_pkg::addr_t   s_ar_addr_i,
  input  axi_ser_chan_pkg::len_t    s_ar_len_i,
  input  logic                      s_r_valid_o,
  input  logic                      s_r_ready_i,
  input  axi_ser_chan_pkg::slv_id_t s_r_id_o,
  input  axi_ser_chan_pkg::data_t   s_r_data_o,
  input  logic                      s_r_last_o,
  input  logic                      m_ar_valid_o,
  input  logic                      m_ar_ready_i,
  input  axi_ser_chan_pkg::mst_id_t m_ar_id_o,
  input  axi_ser_chan_pkg::addr_t   m_ar_addr_o,
  input  axi_ser_chan_pkg::len_t    m_ar_len_o,
  input  logic                      m_r_valid_i,
  input  logic                      m_r_ready_o,
  input  axi_ser_chan_pkg::mst_id_t m_r_id_i,
  output int unsigned               done_count_o,
  output int unsigned               error_count_o
);

  localparam int unsigned NL       = axi_ser_cfg_pkg::NUM_LANES;
  localparam int unsigned MAX_TXNS = axi_ser_cfg_pkg::MAX_TXNS_PER_LANE;

  typedef struct packed {
    logic [NAME_W-1:0]         name;
    axi_ser_chan_pkg::slv_id_t id;
    axi_ser_chan_pkg::addr_t   addr;
    axi_ser_chan_pkg::len_t    len;
    logic [15:0]               errs;
  } burst_t;

  // Accepted on the slave side, not yet seen on the master side
  burst_t      pend_q [NL][$];
  // Issued on the master side, waiting for their last beat
  burst_t      outst_q [NL][$];
  int unsigned beat_cnt [NL];
  int unsigned done_cnt;
  int unsigned err_cnt;
  burst_t      cur;
  int unsigned lane;
  int unsigned bad;
  logic        found;

  assign done_count_o  = done_cnt;
  assign error_count_o = err_cnt;

  function automatic int unsigned mismatch(input logic [NAME_W-1:0] name, input string what,
                                           input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s: %s expected %0h actual %0h", name, what, exp, act);
      return 1;
    end
    return 0;
  endfunction

  // Sampled mid-cycle, a handshake seen here completes at the next rising edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      done_cnt = 0;
      err_cnt  = 0;
      for (int l = 0; l < NL; l++) begin
        pend_q[l].delete();
        outst_q[l].delete();
        beat_cnt[l] = 0;
      end
    end else begin
      if (s_ar_valid_i && s_ar_ready_o) begin
        cur.name = test_name_i;
        cur.id   = s_ar_id_i;
        cur.addr = s_ar_addr_i;
        cur.len  = s_ar_len_i;
        cur.errs = '0;
        pend_q[32'(s_ar_id_i) % NL].push_back(cur);
      end

      if ((m_r_valid_i && m_r_ready_o) != (s_r_valid_o && s_r_ready_i)) begin
        $display("Master and slave R handshakes disagree, a beat was lost or made up");
        err_cnt++;
      end

      if (s_r_valid_o && s_r_ready_i) begin
        lane = 32'(m_r_id_i);
        if (outst_q[lane].size() == 0) begin
          $display("Read beat on master ID %0d with no outstanding burst", lane);
          err_cnt++;
        end else begin
          cur = outst_q[lane][0];
          bad = mismatch(cur.name, "R ID", 32'(cur.id), 32'(s_r_id_o))
              + mismatch(cur.name, "R data", 32'(cur.addr) + beat_cnt[lane], s_r_data_o)
              + mismatch(cur.name, "R last", 32'(beat_cnt[lane] == 32'(cur.len)),
                         32'(s_r_last_o));
          cur.errs = cur.errs + 16'(bad);
          err_cnt  = err_cnt + bad;
          if (beat_cnt[lane] == 32'(cur.len)) begin
            $display("Test %s done, %0d beats, %0d mismatches", cur.name, cur.len + 1,
                     cur.errs);
            void'(outst_q[lane].pop_front());
            beat_cnt[lane] = 0;
            done_cnt++;
          end else begin
            outst_q[lane][0] = cur;
            beat_cnt[lane]++;
          end
        end
      end

      // The request must be the oldest one still pending on its lane
      if (m_ar_valid_o && m_ar_ready_i) begin
        found = 1'b0;
        lane  = 0;
        for (int l = 0; l < NL; l++) begin
          if (!found && pend_q[l].size() > 0 && pend_q[l][0].addr == m_ar_addr_o) begin
            found = 1'b1;
            lane  = l;
          end
        end
        if (!found) begin
          $display("Master AR at address %h matches no oldest pending request", m_ar_addr_o);
          err_cnt++;
        end else begin
          cur = pend_q[lane].pop_front();
          bad = mismatch(cur.name, "master AR ID", lane, 32'(m_ar_id_o))
              + mismatch(cur.name, "master AR length", 32'(cur.len), 32'(m_ar_len_o));
          cur.errs = cur.errs + 16'(bad);
          err_cnt  = err_cnt + bad;
          outst_q[lane].push_back(cur);
          if (outst_q[lane].size() > MAX_TXNS) begin
            $display("Master ID %0d has %0d reads outstanding, more than %0d allowed",
                     lane, outst_q[lane].size(), MAX_TXNS);
            err_cnt++;
          end
        end
      end
    end
  end

endmodule

//--- verification/tb_top.sv
module tb_top;

  localparam int unsigned NL         = axi_ser_cfg_pkg::NUM_LANES;
  localparam int unsigned MAX_TXNS   = axi_ser_cfg_pkg::MAX_TXNS_PER_LANE;
  localparam int unsigned NAME_W     = 80;
  localparam int unsigned NUM_ROWS   = 16;
  localparam int unsigned HOLD_LANE  = 1;
  localparam int unsigned HOLD_DWELL = 20;

  typedef struct packed {
    logic [NAME_W-1:0]         name;
    axi_ser_chan_pkg::slv_id_t id;
    axi_ser_chan_pkg::addr_t   addr;
    axi_ser_chan_pkg::len_t    len;
    logic                      hold;
  } row_t;

  typedef struct packed {
    axi_ser_chan_pkg::addr_t addr;
    axi_ser_chan_pkg::len_t  len;
  } req_t;

  // Name, slave ID, address, length, start withholding lane 1
  localparam row_t ROWS [NUM_ROWS] = '{
    '{"l0_single0", 4'h0, 16'h0100, 8'd0,  1'b0},
    '{"l1_burst03", 4'h1, 16'h0200, 8'd3,  1'b0},
    '{"l2_burst07", 4'h6, 16'h0300, 8'd7,  1'b0},
    '{"l3_burst15", 4'hf, 16'h0400, 8'd15, 1'b0},
    '{"same_id5_a", 4'h5, 16'h0500, 8'd2,  1'b0},
    '{"same_id5_b", 4'h5, 16'h0600, 8'd1,  1'b0},
    '{"same_id5_c", 4'h5, 16'h0700, 8'd4,  1'b0},
    '{"mix_lane_2", 4'ha, 16'h0800, 8'd5,  1'b0},
    '{"mix_lane_0", 4'hc, 16'h0900, 8'd3,  1'b0},
    '{"hold_l1_n1", 4'h1, 16'h1000, 8'd2,  1'b1},
    '{"hold_l1_n2", 4'h5, 16'h1100, 8'd1,  1'b0},
    '{"hold_l1_n3", 4'h9, 16'h1200, 8'd0,  1'b0},
    '{"hold_l1_n4", 4'hd, 16'h1300, 8'd3,  1'b0},
    '{"hold_l1_n5", 4'h1, 16'h1400, 8'd2,  1'b0},
    '{"hol_block2", 4'h2, 16'h1500, 8'd1,  1'b0},
    '{"tail_lane3", 4'h7, 16'h1600, 8'd6,  1'b0}
  };

  logic                      clk_i;
  logic                      rst_i;
  logic                      s_ar_valid_i;
  logic                      s_ar_ready_o;
  axi_ser_chan_pkg::slv_id_t s_ar_id_i;
  axi_ser_chan_pkg::addr_t   s_ar_addr_i;
  axi_ser_chan_pkg::len_t    s_ar_len_i;
  logic                      s_r_valid_o;
  logic                      s_r_ready_i;
  axi_ser_chan_pkg::slv_id_t s_r_id_o;
  axi_ser_chan_pkg::data_t   s_r_data_o;
  logic                      s_r_last_o;
  logic                      m_ar_valid_o;
  logic                      m_ar_ready_i;
  axi_ser_chan_pkg::mst_id_t m_ar_id_o;
  axi_ser_chan_pkg::addr_t   m_ar_addr_o;
  axi_ser_chan_pkg::len_t    m_ar_len_o;
  logic                      m_r_valid_i;
  logic                      m_r_ready_o;
  axi_ser_chan_pkg::mst_id_t m_r_id_i;
  axi_ser_chan_pkg::data_t   m_r_data_i;
  logic                      m_r_last_i;

  logic [NAME_W-1:0] test_name;
  int unsigned       done_count;
  int unsigned       error_count;

  // Master-side memory model state
  req_t        mem_q [NL][$];
  int unsigned cand_q [$];
  logic        hold_lane;
  logic        busy;
  logic        r_fire;
  int unsigned cur_lane;
  int unsigned beat;
  int unsigned dwell;
  req_t        req;

  always #5 clk_i = ~clk_i;

  axi_id_serialize_rd i_dut (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .s_ar_valid_i ( s_ar_valid_i ),
    .s_ar_ready_o ( s_ar_ready_o ),
    .s_ar_id_i    ( s_ar_id_i    ),
    .s_ar_addr_i  ( s_ar_addr_i  ),
    .s_ar_len_i   ( s_ar_len_i   ),
    .s_r_valid_o  ( s_r_valid_o  ),
    .s_r_ready_i  ( s_r_ready_i  ),
    .s_r_id_o     ( s_r_id_o     ),
    .s_r_data_o   ( s_r_data_o   ),
    .s_r_last_o   ( s_r_last_o   ),
    .m_ar_valid_o ( m_ar_valid_o ),
    .m_ar_ready_i ( m_ar_ready_i ),
    .m_ar_id_o    ( m_ar_id_o    ),
    .m_ar_addr_o  ( m_ar_addr_o  ),
    .m_ar_len_o   ( m_ar_len_o   ),
    .m_r_valid_i  ( m_r_valid_i  ),
    .m_r_ready_o  ( m_r_ready_o  ),
    .m_r_id_i     ( m_r_id_i     ),
    .m_r_data_i   ( m_r_data_i   ),
    .m_r_last_i   ( m_r_last_i   )
  );

  tb_checker #(
    .NAME_W ( NAME_W )
  ) i_tb_checker (
    .clk_i         ( clk_i        ),
    .rst_i         ( rst_i        ),
    .test_name_i   ( test_name    ),
    .s_ar_valid_i  ( s_ar_valid_i ),
    .s_ar_ready_o  ( s_ar_ready_o ),
    .s_ar_id_i     ( s_ar_id_i    ),
    .s_ar_addr_i   ( s_ar_addr_i  ),
    .s_ar_len_i    ( s_ar_len_i   ),
    .s_r_valid_o   ( s_r_valid_o  ),
    .s_r_ready_i   ( s_r_ready_i  ),
    .s_r_id_o      ( s_r_id_o     ),
    .s_r_data_o    ( s_r_data_o   ),
    .s_r_last_o    ( s_r_last_o   ),
    .m_ar_valid_o  ( m_ar_valid_o ),
    .m_ar_ready_i  ( m_ar_ready_i ),
    .m_ar_id_o     ( m_ar_id_o    ),
    .m_ar_addr_o   ( m_ar_addr_o  ),
    .m_ar_len_o    ( m_ar_len_o   ),
    .m_r_valid_i   ( m_r_valid_i  ),
    .m_r_ready_o   ( m_r_ready_o  ),
    .m_r_id_i      ( m_r_id_i     ),
    .done_count_o  ( done_count   ),
    .error_count_o ( error_count  )
  );

  // Present one request and hold it until the DUT takes it
  task automatic apply_row(input row_t row);
    s_ar_valid_i = 1'b1;
    s_ar_id_i    = row.id;
    s_ar_addr_i  = row.addr;
    s_ar_len_i   = row.len;
    test_name    = row.name;
    @(negedge clk_i);
    while (!s_ar_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    // Withholding starts at the handshake of the marked row
    if (row.hold) begin
      hold_lane = 1'b1;
    end
    #1;
    s_ar_valid_i = 1'b0;
    repeat ($urandom_range(2)) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  initial begin
    void'($urandom(18));
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    s_ar_valid_i = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_r_ready_i  = 1'b0;
    m_ar_ready_i = 1'b0;
    m_r_valid_i  = 1'b0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_last_i   = 1'b0;
    test_name    = '0;
    hold_lane    = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(ROWS[r]);
    end
    while (done_count < NUM_ROWS) begin
      @(posedge clk_i);
    end
    repeat (5) @(posedge clk_i);
    $display("Tests completed %0d of %0d, errors %0d", done_count, NUM_ROWS, error_count);
    if (error_count == 0 && done_count == NUM_ROWS) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Memory model, samples mid-cycle and drives just after the rising edge
  initial begin
    busy     = 1'b0;
    beat     = 0;
    cur_lane = 0;
    dwell    = 0;
    wait (rst_i === 1'b0);
    forever begin
      @(negedge clk_i);
      if (m_ar_valid_o && m_ar_ready_i) begin
        req.addr = m_ar_addr_o;
        req.len  = m_ar_len_o;
        mem_q[32'(m_ar_id_o)].push_back(req);
      end
      r_fire = m_r_valid_i && m_r_ready_o;
      if (hold_lane && mem_q[HOLD_LANE].size() >= MAX_TXNS) begin
        dwell++;
      end
      @(posedge clk_i);
      #1;
      // Lane 1 stays full long enough for the next same-lane request to stall
      if (dwell >= HOLD_DWELL) begin
        hold_lane = 1'b0;
        dwell     = 0;
      end
      if (r_fire) begin
        if (m_r_last_i) begin
          void'(mem_q[cur_lane].pop_front());
          busy = 1'b0;
        end else begin
          beat++;
        end
      end
      if (!busy) begin
        cand_q.delete();
        for (int l = 0; l < NL; l++) begin
          if (mem_q[l].size() > 0 && !(hold_lane && l == HOLD_LANE)) begin
            cand_q.push_back(l);
          end
        end
        if (cand_q.size() > 0) begin
          cur_lane = cand_q[$urandom_range(cand_q.size() - 1)];
          beat     = 0;
          busy     = 1'b1;
        end
      end
      m_r_valid_i = busy;
      if (busy) begin
        m_r_id_i   = axi_ser_chan_pkg::mst_id_t'(cur_lane);
        m_r_data_i = axi_ser_chan_pkg::data_t'(mem_q[cur_lane][0].addr) + beat;
        m_r_last_i = (beat == 32'(mem_q[cur_lane][0].len));
      end
      m_ar_ready_i = ($urandom_range(3) != 0);
      s_r_ready_i  = ($urandom_range(3) != 0);
    end
  end

  // Watchdog sized from the longest burst in the table
  initial begin
    int unsigned max_len;
    int unsigned limit;
    max_len = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (32'(ROWS[r].len) > max_len) begin
        max_len = 32'(ROWS[r].len);
      end
    end
    limit = NUM_ROWS * (max_len + 1) * 50;
    repeat (limit) @(posedge clk_i);
    $display("Timeout after %0d cycles, only %0d of %0d tests finished",
             limit, done_count, NUM_ROWS);
    $display("Simulation failed");
    $finish;
  end

endmodule
